// ==== src/bus_pkg.sv ====
/* Tagged memory bus types, 64-bit address and 64-bit line
   Tag 0 means no transaction in both response and tag fields
   BUS_STORE is defined for completeness and never driven by fetch */
`default_nettype none

package bus_pkg;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  typedef logic [3:0] mem_tag_t;  // 0 is reserved for "none"

  // One memory line, filled whole and read back as two instructions
  typedef union packed {
    logic [63:0]      word;
    logic [1:0][31:0] inst;  // inst[0] is the lower address
  } mem_line_u;

  typedef struct packed {
    bus_cmd_e    command;
    logic [63:0] addr;  // 8-byte aligned
  } mem_req_t;

  typedef struct packed {
    mem_tag_t  response;  // Same-cycle accept tag, 0 rejects
    mem_line_u data;
    mem_tag_t  tag;       // Marks the cycle data is valid
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== src/fetch_pkg.sv ====
/* Fetch side types, IF/ID packet and cache fill
   Line addresses are pc[63:3], one 64-bit line per address */
`default_nettype none

package fetch_pkg;

  typedef logic [60:0] line_addr_t;

  // IF/ID register contents
  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic [63:0] npc;   // pc + 4
    logic [31:0] inst;
  } fetch_packet_t;

  // Write port into the cache array
  typedef struct packed {
    logic               en;
    line_addr_t         line_addr;
    bus_pkg::mem_line_u data;
  } cache_fill_t;

endpackage

`default_nettype wire

// ==== src/icache_mem.sv ====
/* Direct-mapped I-cache array, one 64-bit line per entry
   NUM_LINES must be a power of two, at least 2
   Read and hit check are combinational, fills land at the clock edge */
`timescale 1ns/1ns
`default_nettype none

module icache_mem #(
  parameter int NUM_LINES = 32
) (
  input  wire                         clock,
  input  wire                         reset,
  input  wire fetch_pkg::line_addr_t  fetch_line,
  input  wire fetch_pkg::cache_fill_t fill,
  output logic                        rd_hit,
  output bus_pkg::mem_line_u          rd_line
);

  localparam int ADDR_W = $bits(fetch_pkg::line_addr_t);
  localparam int IDX_W  = $clog2(NUM_LINES);
  localparam int TAG_W  = ADDR_W - IDX_W;

  logic [NUM_LINES-1:0] valid;
  logic [TAG_W-1:0]     tags  [NUM_LINES];
  bus_pkg::mem_line_u   lines [NUM_LINES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;

  // Index from the low line bits, tag from the rest
  assign rd_idx = fetch_line[IDX_W-1:0];
  assign rd_tag = fetch_line[ADDR_W-1:IDX_W];
  assign wr_idx = fill.line_addr[IDX_W-1:0];
  assign wr_tag = fill.line_addr[ADDR_W-1:IDX_W];

  assign rd_hit  = valid[rd_idx] && (tags[rd_idx] == rd_tag);
  assign rd_line = lines[rd_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;                  // Cold cache
    end else if (fill.en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill.en) begin
      tags[wr_idx]  <= wr_tag;
      lines[wr_idx] <= fill.data;
    end
  end

  // Miss controller must be quiet for the whole reset window
  a_no_fill_in_reset: assert property (
    @(posedge clock) reset |-> (fill.en !== 1'b1)
  ) else $error("icache_mem: fill written during reset");

endmodule

`default_nettype wire

// ==== src/icache_ctrl.sv ====
/* I-cache miss controller, one outstanding load at a time
   Rejected loads (response 0) are offered again the next cycle
   A fill in flight completes even if fetch has moved elsewhere */
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
  input  wire                         clock,
  input  wire                         reset,
  input  wire fetch_pkg::line_addr_t  fetch_line,
  input  wire                         rd_hit,
  input  wire bus_pkg::mem_rsp_t      mem_rsp,
  output bus_pkg::mem_req_t           mem_req,
  output fetch_pkg::cache_fill_t      fill
);

  typedef enum logic [1:0] {
    IDLE    = 2'h0,
    REQUEST = 2'h1,
    WAIT    = 2'h2
  } state_e;

  state_e                state;
  state_e                state_next;
  fetch_pkg::line_addr_t miss_line;  // Line being fetched
  bus_pkg::mem_tag_t     miss_tag;   // Tag handed back on accept
  logic                  accepted;
  logic                  tag_match;

  assign accepted  = (state == REQUEST) && (mem_rsp.response != '0);
  assign tag_match = (state == WAIT) && (mem_rsp.tag == miss_tag);

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (!rd_hit) begin
          state_next = REQUEST;
        end
      end
      REQUEST: begin
        if (accepted) begin
          state_next = WAIT;
        end
      end
      WAIT: begin
        if (tag_match) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == IDLE && !rd_hit) begin
      miss_line <= fetch_line;       // Held until the fill
    end
    if (accepted) begin
      miss_tag <= mem_rsp.response;
    end
  end

  //////////////////////////////
  // Bus and fill outputs
  //////////////////////////////
  always_comb begin
    mem_req.command = (state == REQUEST) ? bus_pkg::BUS_LOAD : bus_pkg::BUS_NONE;
    mem_req.addr    = {miss_line, 3'b000};
    fill.en         = tag_match;     // Written at this edge, hit next cycle
    fill.line_addr  = miss_line;
    fill.data       = mem_rsp.data;
  end

  // An accepted load is not offered again before its data returns
  a_load_only_in_request: assert property (
    @(posedge clock) disable iff (reset)
    accepted |=> (mem_req.command != bus_pkg::BUS_LOAD) until fill.en
  ) else $error("icache_ctrl: load offered while one is outstanding");

  a_no_store: assert property (
    @(posedge clock) disable iff (reset)
    mem_req.command != bus_pkg::BUS_STORE
  ) else $error("icache_ctrl: store on instruction bus");

  // Fill closes the miss, so the FSM is idle right after
  a_fill_in_wait: assert property (
    @(posedge clock) disable iff (reset)
    fill.en |-> (state == WAIT) ##1 (state == IDLE)
  ) else $error("icache_ctrl: fill outside WAIT");

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
/* Program counter and IF/ID register
   take_branch wins over get_next_inst, targets must be 4-byte aligned
   Packet holds on stall, valid drops on a miss */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  wire                      clock,
  input  wire                      reset,
  input  wire                      get_next_inst,
  input  wire                      take_branch,
  input  wire [63:0]               branch_target,
  input  wire                      rd_hit,
  input  wire bus_pkg::mem_line_u  rd_line,
  output fetch_pkg::line_addr_t    fetch_line,
  output fetch_pkg::fetch_packet_t fetch_out
);

  logic [63:0] pc;
  logic [63:0] pc_plus4;
  logic [31:0] inst;

  assign pc_plus4   = pc + 64'd4;
  assign fetch_line = pc[63:3];
  assign inst       = rd_line.inst[pc[2]];  // Half of the line for this pc

  //////////////////////////////
  // PC and IF/ID register
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      pc              <= '0;
      fetch_out.valid <= 1'b0;
    end else if (take_branch) begin
      pc              <= branch_target;    // Redirect, drop what we had
      fetch_out.valid <= 1'b0;
    end else if (get_next_inst) begin
      if (rd_hit) begin
        fetch_out.valid <= 1'b1;
        fetch_out.pc    <= pc;
        fetch_out.npc   <= pc_plus4;
        fetch_out.inst  <= inst;
        pc              <= pc_plus4;
      end else begin
        // Miss, wait for the fill with pc held
        fetch_out.valid <= 1'b0;
      end
    end
  end

  a_branch_aligned: assert property (
    @(posedge clock) disable iff (reset)
    take_branch |-> (branch_target[1:0] == 2'b00)
  ) else $error("fetch_stage: unaligned branch target %h", branch_target);

endmodule

`default_nettype wire

// ==== src/fetch_top.sv ====
/* Instruction fetch front end, instances and wiring only
   The instruction side owns the memory bus, no data-side arbitration
   NUM_LINES sets the I-cache depth, power of two */
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
  parameter int NUM_LINES = 32
) (
  input  wire                      clock,
  input  wire                      reset,
  input  wire                      get_next_inst,
  input  wire                      take_branch,
  input  wire [63:0]               branch_target,
  input  wire bus_pkg::mem_rsp_t   mem_rsp,
  output bus_pkg::mem_req_t        mem_req,
  output fetch_pkg::fetch_packet_t fetch_out
);

  fetch_pkg::line_addr_t  fetch_line;  // Line of the current pc
  logic                   rd_hit;
  bus_pkg::mem_line_u     rd_line;
  fetch_pkg::cache_fill_t fill;

  //////////////////////////////
  // Cache array
  //////////////////////////////
  icache_mem #(
    .NUM_LINES (NUM_LINES)
  ) icache_mem_i (
    .clock      (clock),
    .reset      (reset),
    .fetch_line (fetch_line),
    .fill       (fill),
    .rd_hit     (rd_hit),
    .rd_line    (rd_line)
  );

  icache_ctrl icache_ctrl_i (
    .clock      (clock),
    .reset      (reset),
    .fetch_line (fetch_line),
    .rd_hit     (rd_hit),
    .mem_rsp    (mem_rsp),
    .mem_req    (mem_req),
    .fill       (fill)
  );

  //////////////////////////////
  // PC and IF/ID
  //////////////////////////////
  fetch_stage fetch_stage_i (
    .clock         (clock),
    .reset         (reset),
    .get_next_inst (get_next_inst),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .rd_hit        (rd_hit),
    .rd_line       (rd_line),
    .fetch_line    (fetch_line),
    .fetch_out     (fetch_out)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
/* Testbench clock and synchronous reset
   Reset drops 2 ns after the last reset edge, like every other input */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #2 reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== verification/mem_model.sv ====
/* Tagged memory model for the instruction bus
   Holds one load at a time, rejects about one in four, data 2 to 9 cycles later
   Line contents arrive on line_data for the address shown on data_addr */
`timescale 1ns/1ns
`default_nettype none

module mem_model #(
  parameter logic [31:0] SEED = 32'hfe31834f
) (
  input  wire                     clock,
  input  wire                     reset,
  input  wire bus_pkg::mem_req_t  mem_req,
  input  wire bus_pkg::mem_line_u line_data,
  output bus_pkg::mem_rsp_t       mem_rsp,
  output logic [63:0]             data_addr,
  output logic                    busy,
  output int                      reject_count,
  output int                      overlap_count
);

  logic [31:0]       rng;
  bus_pkg::mem_tag_t next_tag;
  bus_pkg::mem_tag_t cur_tag;
  int                wait_cnt;
  logic              was_busy;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    mem_rsp       = '0;
    data_addr     = '0;
    busy          = 1'b0;
    rng           = SEED;
    next_tag      = 4'd1;
    cur_tag       = '0;
    wait_cnt      = 0;
    reject_count  = 0;
    overlap_count = 0;
  end

  //////////////////////////////
  // One bus cycle per clock
  //////////////////////////////
  always @(posedge clock) begin
    #2;
    mem_rsp.response = '0;
    mem_rsp.tag      = '0;
    mem_rsp.data     = '0;
    was_busy         = busy;
    if (reset) begin
      busy = 1'b0;
    end else begin
      if (mem_req.command == bus_pkg::BUS_LOAD) begin
        rng = xorshift32(rng);
        if (was_busy) begin
          overlap_count++;                  // Second load while one is open
        end else if (rng[1:0] == 2'b00) begin
          reject_count++;
        end else begin
          mem_rsp.response = next_tag;      // Accept in the same cycle
          cur_tag          = next_tag;
          data_addr        = mem_req.addr;
          wait_cnt         = 2 + int'(rng[10:8]);
          busy             = 1'b1;
          next_tag         = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
      end
      if (was_busy) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          mem_rsp.tag  = cur_tag;
          mem_rsp.data = line_data;
          busy         = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/fetch_tb.sv ====
/* Testbench for fetch_top with mem_model serving the bus
   Inputs change 2 ns after the rising edge, outputs are read at the falling edge
   Every wait gives up after 200 cycles */
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

  localparam int WAIT_LIMIT = 200;

  logic                     clock;
  logic                     reset;
  logic                     get_next_inst;
  logic                     take_branch;
  logic [63:0]              branch_target;
  bus_pkg::mem_req_t        mem_req;
  bus_pkg::mem_rsp_t        mem_rsp;
  fetch_pkg::fetch_packet_t fetch_out;
  bus_pkg::mem_line_u       model_line;
  logic [63:0]              model_addr;
  logic                     model_busy;
  int                       reject_count;
  int                       overlap_count;

  logic                     gni_q;      // Inputs as seen at the last edge
  logic                     branch_q;
  logic [63:0]              target_q;
  logic [63:0]              exp_pc;
  logic                     quiet_bus;  // No load may appear
  fetch_pkg::fetch_packet_t last_seen;
  fetch_pkg::fetch_packet_t last_good;
  fetch_pkg::fetch_packet_t held;
  int                       pkt_count = 0;
  int                       check_count = 0;
  int                       error_count = 0;
  int                       test_count = 0;
  int                       test_base = 0;
  int                       reject_base = 0;

  tb_clock #(.PERIOD(20), .RESET_CYCLES(16)) tb_clock_i (.clock(clock), .reset(reset));

  mem_model #(.SEED(32'hfe31834f)) mem_model_i (
    .clock(clock),               .reset(reset),
    .mem_req(mem_req),           .line_data(model_line),
    .mem_rsp(mem_rsp),           .data_addr(model_addr),
    .busy(model_busy),           .reject_count(reject_count),
    .overlap_count(overlap_count)
  );

  fetch_top #(.NUM_LINES(32)) fetch_top_i (
    .clock         (clock),
    .reset         (reset),
    .get_next_inst (get_next_inst),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .mem_rsp       (mem_rsp),
    .mem_req       (mem_req),
    .fetch_out     (fetch_out)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Address XOR a constant, rotated left by 11
  function automatic logic [31:0] mem_word(input logic [63:0] addr);
    logic [31:0] mixed;
    mixed = addr[31:0] ^ addr[63:32] ^ 32'h6b2fd153;
    return {mixed[20:0], mixed[31:21]};
  endfunction

  function automatic fetch_pkg::fetch_packet_t expected_packet(input logic [63:0] pc);
    fetch_pkg::fetch_packet_t pkt;
    pkt.valid = 1'b1;
    pkt.pc    = pc;
    pkt.npc   = pc + 64'd4;
    pkt.inst  = mem_word(pc);
    return pkt;
  endfunction

  always_comb begin
    model_line.word = {mem_word(model_addr + 64'd4), mem_word(model_addr)};  // Lower half first
  end

  //////////////////////////////
  // Checks and reporting
  //////////////////////////////
  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    error_count++;
    $display("error t=%0t %s got %h expected %h", $time, name, got, exp);
  endtask

  // Invalid expected packet pins only valid
  task automatic check_packet(input string name, input fetch_pkg::fetch_packet_t got,
                              input fetch_pkg::fetch_packet_t exp);
    check_count++;
    if (got.valid !== exp.valid) begin
      report_mismatch({name, ".valid"}, got.valid, exp.valid);
    end else if (exp.valid) begin
      if (got.pc !== exp.pc) report_mismatch({name, ".pc"}, got.pc, exp.pc);
      if (got.npc !== exp.npc) report_mismatch({name, ".npc"}, got.npc, exp.npc);
      if (got.inst !== exp.inst) report_mismatch({name, ".inst"}, got.inst, exp.inst);
    end
  endtask

  task automatic check_cmd(input string name, input bus_pkg::bus_cmd_e got,
                           input bus_pkg::bus_cmd_e exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("failure t=%0t %s", $time, what);
  endtask

  task automatic abort_run(input string what);
    $display("timeout t=%0t waited %0d cycles for %s", $time, WAIT_LIMIT, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, error_count - test_base);
    test_base = error_count;
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  task automatic next_slot();
    @(posedge clock);
    #2;
  endtask

  task automatic wait_reset_done();
    int n;
    n = 0;
    @(negedge clock);
    while (reset) begin
      if (n == WAIT_LIMIT) abort_run("reset release");
      @(negedge clock);
      n++;
    end
  endtask

  task automatic fetch_run(input int count, input string what);
    int start;
    int n;
    repeat (count) begin
      start = pkt_count;
      n     = 0;
      while (pkt_count == start) begin
        if (n == WAIT_LIMIT) abort_run(what);
        next_slot();
        n++;
      end
    end
  endtask

  // Bus quiet for three cycles in a row, nothing outstanding
  task automatic wait_bus_idle();
    int n;
    int quiet;
    n     = 0;
    quiet = 0;
    while (quiet < 3) begin
      if (n == WAIT_LIMIT) abort_run("an idle bus");
      @(negedge clock);
      n++;
      if (mem_req.command == bus_pkg::BUS_NONE && !model_busy) quiet++;
      else quiet = 0;
    end
  endtask

  task automatic branch_to(input logic [63:0] target);
    next_slot();
    take_branch   = 1'b1;
    branch_target = target;
    get_next_inst = 1'b1;
    next_slot();
    take_branch = 1'b0;
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////
  always @(posedge clock) begin
    gni_q    <= get_next_inst;
    branch_q <= take_branch;
    target_q <= branch_target;
  end

  always @(negedge clock) begin
    if (reset) begin
      exp_pc = '0;
    end else if (branch_q) begin
      exp_pc = target_q;
      check_packet("fetch_out after branch", fetch_out, '0);
    end else if (!gni_q) begin
      check_packet("fetch_out on stall", fetch_out, last_seen);  // Must hold
    end else if (fetch_out.valid) begin
      check_packet("fetch_out", fetch_out, expected_packet(exp_pc));
      exp_pc    = exp_pc + 64'd4;
      last_good = fetch_out;
      pkt_count++;
    end
    if (quiet_bus) check_cmd("mem_req.command", mem_req.command, bus_pkg::BUS_NONE);
    last_seen = fetch_out;
  end

  initial begin
    get_next_inst = 1'b0;
    take_branch   = 1'b0;
    branch_target = '0;
    quiet_bus     = 1'b0;

    wait_reset_done();
    check_packet("fetch_out", fetch_out, '0);
    check_cmd("mem_req.command", mem_req.command, bus_pkg::BUS_NONE);
    end_test("reset state");

    next_slot();
    get_next_inst = 1'b1;
    fetch_run(40, "a packet from the cold cache");
    get_next_inst = 1'b0;
    wait_bus_idle();                  // Line 20 is still being filled
    end_test("sequential fetch from a cold cache");

    branch_to(64'h0);
    quiet_bus = 1'b1;
    fetch_run(40, "a packet from the warm cache");
    get_next_inst = 1'b0;
    next_slot();
    quiet_bus = 1'b0;
    end_test("hits without bus traffic");

    get_next_inst = 1'b1;
    fetch_run(3, "a packet before the branch");
    branch_to(64'h1000);              // Likely lands while a miss is open
    fetch_run(12, "a packet after the branch");
    get_next_inst = 1'b0;
    wait_bus_idle();
    end_test("branch redirect");

    reject_base = reject_count;
    branch_to(64'h40000);
    fetch_run(48, "a packet with rejected loads");
    get_next_inst = 1'b0;
    wait_bus_idle();
    if (reject_count == reject_base) report_failure("the memory model rejected no load");
    if (overlap_count != 0) report_failure("a load was offered while another was outstanding");
    end_test("rejected loads are retried");

    next_slot();
    get_next_inst = 1'b1;
    fetch_run(1, "a packet before the stall");
    get_next_inst = 1'b0;             // Stall starts with a valid packet held
    next_slot();
    held = last_good;
    repeat (8) next_slot();
    get_next_inst = 1'b1;
    fetch_run(1, "the packet after the stall");
    check_packet("fetch_out after stall", last_good, expected_packet(held.pc + 64'd4));
    end_test("stall");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/bus_pkg.sv
src/fetch_pkg.sv
src/icache_mem.sv
src/icache_ctrl.sv
src/fetch_stage.sv
src/fetch_top.sv
verification/tb_clock.sv
verification/mem_model.sv
verification/fetch_tb.sv
